//--- hdl/noc_macros.svh
`ifndef NOC_MACROS_SVH
`define NOC_MACROS_SVH

// router ports
`define NOC_P 5

`define NOC_PORT_LOCAL 0
`define NOC_PORT_EAST  1
`define NOC_PORT_NORTH 2
`define NOC_PORT_WEST  3
`define NOC_PORT_SOUTH 4

// input FIFO depth, also the credits each output starts with
`define NOC_BUF_DEPTH 4
`define NOC_CRD_W     3 // holds 0 .. NOC_BUF_DEPTH

// one mesh coordinate
`define NOC_XY_W 4

// flit data word
`define NOC_PAY_W 32

`endif

//--- hdl/noc_pkg.sv
`default_nettype none

`include "noc_macros.svh"

package noc_pkg;

	// head flit view of the data word
	typedef struct packed {
		logic [`NOC_XY_W-1:0]               dest_x;
		logic [`NOC_XY_W-1:0]               dest_y;
		logic [`NOC_PAY_W-2*`NOC_XY_W-1:0]  tag;
	} flit_hdr_t;

	// head flits decode hdr, body and tail flits carry raw payload
	typedef union packed {
		flit_hdr_t              hdr;
		logic [`NOC_PAY_W-1:0]  raw;
	} flit_data_u;

	typedef struct packed {
		logic        head;
		logic        tail;
		flit_data_u  data;
	} flit_t;

	// one bit per router port
	typedef logic [`NOC_P-1:0] port_vec_t;

	// grant over the other four ports, sender removed
	// ports below the sender keep their index, ports above shift down by one
	typedef logic [`NOC_P-2:0] dest_ex_t;

endpackage

`default_nettype wire

//--- hdl/input_port.sv
`timescale 1ns/1ns
`default_nettype none

`include "noc_macros.svh"

module input_port #(
	parameter int unsigned ROUTER_X = 0,
	parameter int unsigned ROUTER_Y = 0,
	parameter int unsigned SW_LOC   = 0
) (
	input  logic                clk,
	input  logic                reset,
	input  noc_pkg::flit_t      flit_in,
	input  logic                flit_we,
	input  noc_pkg::dest_ex_t   grant,
	output noc_pkg::port_vec_t  req,
	output noc_pkg::flit_t      head_flit,
	output logic                is_tail,
	output logic                credit_out
);

	localparam int PTR_W = $clog2(`NOC_BUF_DEPTH);
	localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(`NOC_BUF_DEPTH - 1);
	localparam logic [`NOC_XY_W-1:0] MY_X = ROUTER_X[`NOC_XY_W-1:0];
	localparam logic [`NOC_XY_W-1:0] MY_Y = ROUTER_Y[`NOC_XY_W-1:0];
	localparam noc_pkg::port_vec_t SELF = noc_pkg::port_vec_t'(1) << SW_LOC;

	noc_pkg::flit_t mem [`NOC_BUF_DEPTH];

	logic [PTR_W-1:0]       wr_ptr;
	logic [PTR_W-1:0]       rd_ptr;
	logic [`NOC_CRD_W-1:0]  count;
	logic                   pop;
	noc_pkg::flit_hdr_t     hdr;
	noc_pkg::port_vec_t     xy_route;
	noc_pkg::port_vec_t     route_q;
	noc_pkg::port_vec_t     route_cur;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_LAST) ? '0 : p + 1'b1;
	endfunction

	assign pop       = |grant; // allocator granted our head flit
	assign head_flit = mem[rd_ptr];
	assign is_tail   = head_flit.tail;
	assign hdr       = head_flit.data.hdr;

	// dimension ordered, x first
	// north is the direction of growing y
	always_comb begin
		xy_route = '0;
		if (hdr.dest_x > MY_X) begin
			xy_route[`NOC_PORT_EAST] = 1'b1;
		end else if (hdr.dest_x < MY_X) begin
			xy_route[`NOC_PORT_WEST] = 1'b1;
		end else if (hdr.dest_y > MY_Y) begin
			xy_route[`NOC_PORT_NORTH] = 1'b1;
		end else if (hdr.dest_y < MY_Y) begin
			xy_route[`NOC_PORT_SOUTH] = 1'b1;
		end else begin
			xy_route[`NOC_PORT_LOCAL] = 1'b1;
		end
	end

	// body and tail flits reuse the head's route
	assign route_cur = head_flit.head ? xy_route : route_q;

	always_comb begin
		req = '0;
		if (count != '0) begin
			req = route_cur & ~SELF; // no u-turn
		end
	end

	always_ff @(posedge clk) begin
		if (flit_we) begin
			mem[wr_ptr] <= flit_in;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			route_q    <= '0;
			credit_out <= 1'b0;
		end else begin
			if (flit_we) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (pop) begin
				rd_ptr  <= ptr_inc(rd_ptr);
				route_q <= route_cur;
			end
			case ({flit_we, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			credit_out <= pop; // slot freed, lines up with the crossbar register
		end
	end

endmodule

`default_nettype wire

//--- hdl/switch_alloc.sv
`timescale 1ns/1ns
`default_nettype none

`include "noc_macros.svh"

module switch_alloc (
	input  logic                clk,
	input  logic                reset,
	input  noc_pkg::port_vec_t  req [`NOC_P],
	input  noc_pkg::port_vec_t  is_tail,
	input  noc_pkg::port_vec_t  credit_in,
	output noc_pkg::dest_ex_t   grant [`NOC_P]
);

	localparam int IDX_W = $clog2(`NOC_P);
	localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(`NOC_P - 1);
	localparam logic [`NOC_CRD_W-1:0] CRD_INIT = `NOC_CRD_W'(`NOC_BUF_DEPTH);

	// per output state
	noc_pkg::port_vec_t     locked;
	noc_pkg::port_vec_t     owner [`NOC_P]; // one-hot input holding the lock
	logic [`NOC_CRD_W-1:0]  credit [`NOC_P];
	logic [IDX_W-1:0]       rr_ptr [`NOC_P];

	noc_pkg::port_vec_t     cand [`NOC_P];    // eligible inputs per output
	noc_pkg::port_vec_t     gnt_out [`NOC_P]; // one-hot winner per output
	logic [IDX_W-1:0]       winner [`NOC_P];

	always_comb begin
		for (int o = 0; o < `NOC_P; o++) begin
			for (int i = 0; i < `NOC_P; i++) begin
				cand[o][i] = req[i][o] & (~locked[o] | owner[o][i]) & (credit[o] != '0);
			end
		end
	end

	// round robin, search starts at the pointer
	always_comb begin
		logic found;
		int   idx;
		found = 1'b0;
		idx   = 0;
		for (int o = 0; o < `NOC_P; o++) begin
			gnt_out[o] = '0;
			winner[o]  = '0;
			found      = 1'b0;
			for (int k = 0; k < `NOC_P; k++) begin
				idx = (int'(rr_ptr[o]) + k) % `NOC_P;
				if (!found && cand[o][idx]) begin
					found           = 1'b1;
					gnt_out[o][idx] = 1'b1;
					winner[o]       = IDX_W'(idx);
				end
			end
		end
	end

	// output-major grants to sender-stripped form per input
	always_comb begin
		for (int i = 0; i < `NOC_P; i++) begin
			grant[i] = '0;
			for (int o = 0; o < `NOC_P; o++) begin
				if (o < i) begin
					grant[i][o] = gnt_out[o][i];
				end else if (o > i) begin
					grant[i][o-1] = gnt_out[o][i];
				end
			end
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			locked <= '0;
			for (int o = 0; o < `NOC_P; o++) begin
				owner[o]  <= '0;
				credit[o] <= CRD_INIT;
				rr_ptr[o] <= '0;
			end
		end else begin
			for (int o = 0; o < `NOC_P; o++) begin
				if (|gnt_out[o]) begin
					rr_ptr[o] <= (winner[o] == IDX_LAST) ? '0 : winner[o] + 1'b1;
					if (|(gnt_out[o] & is_tail)) begin
						locked[o] <= 1'b0; // tail or single flit packet
					end else begin
						locked[o] <= 1'b1;
						owner[o]  <= gnt_out[o];
					end
				end
				case ({|gnt_out[o], credit_in[o]})
					2'b10:   credit[o] <= credit[o] - 1'b1;
					2'b01:   credit[o] <= credit[o] + 1'b1;
					default: credit[o] <= credit[o]; // both or neither
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/crossbar.sv
`timescale 1ns/1ns
`default_nettype none

`include "noc_macros.svh"

module crossbar (
	input  logic                clk,
	input  logic                reset,
	input  noc_pkg::dest_ex_t   granted_dest [`NOC_P],
	input  noc_pkg::flit_t      flit_head [`NOC_P],
	output noc_pkg::flit_t      flit_out [`NOC_P],
	output noc_pkg::port_vec_t  flit_out_we
);

	localparam int SEL_W = $clog2(`NOC_P - 1);

	noc_pkg::flit_t      flit_nxt [`NOC_P];
	noc_pkg::port_vec_t  we_nxt;

	for (genvar i = 0; i < `NOC_P; i++) begin : g_out
		noc_pkg::flit_t     mux_in [`NOC_P-1]; // inputs other than port i
		noc_pkg::dest_ex_t  sel;
		logic [SEL_W-1:0]   sel_bin;

		// drop port i from its own candidate list
		for (genvar j = 0; j < `NOC_P; j++) begin : g_in
			if (j < i) begin : g_below
				assign mux_in[j] = flit_head[j];
				assign sel[j]    = granted_dest[j][i-1];
			end else if (j > i) begin : g_above
				assign mux_in[j-1] = flit_head[j];
				assign sel[j-1]    = granted_dest[j][i];
			end
		end

		// one-hot to binary
		always_comb begin
			sel_bin = '0;
			for (int k = 0; k < `NOC_P - 1; k++) begin
				if (sel[k]) begin
					sel_bin = sel_bin | SEL_W'(k);
				end
			end
		end

		assign flit_nxt[i] = mux_in[sel_bin];
		assign we_nxt[i]   = |sel; // any input granted to this output
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			flit_out_we <= '0;
			for (int o = 0; o < `NOC_P; o++) begin
				flit_out[o] <= '0;
			end
		end else begin
			flit_out_we <= we_nxt;
			for (int o = 0; o < `NOC_P; o++) begin
				flit_out[o] <= flit_nxt[o];
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/router_switch.sv
`timescale 1ns/1ns
`default_nettype none

`include "noc_macros.svh"

module router_switch #(
	parameter int unsigned ROUTER_X = 0,
	parameter int unsigned ROUTER_Y = 0
) (
	input  logic                clk,
	input  logic                reset,
	input  noc_pkg::flit_t      flit_in [`NOC_P],
	input  noc_pkg::port_vec_t  flit_in_we,
	output noc_pkg::port_vec_t  credit_out,
	output noc_pkg::flit_t      flit_out [`NOC_P],
	output noc_pkg::port_vec_t  flit_out_we,
	input  noc_pkg::port_vec_t  credit_in
);

	noc_pkg::port_vec_t  req [`NOC_P];
	noc_pkg::flit_t      head_flit [`NOC_P];
	noc_pkg::port_vec_t  is_tail;
	noc_pkg::dest_ex_t   grant [`NOC_P];

	for (genvar p = 0; p < `NOC_P; p++) begin : g_port
		input_port #(
			.ROUTER_X (ROUTER_X),
			.ROUTER_Y (ROUTER_Y),
			.SW_LOC   (p)
		) i_input_port (
			.clk        (clk),
			.reset      (reset),
			.flit_in    (flit_in[p]),
			.flit_we    (flit_in_we[p]),
			.grant      (grant[p]),
			.req        (req[p]),
			.head_flit  (head_flit[p]),
			.is_tail    (is_tail[p]),
			.credit_out (credit_out[p])
		);
	end

	switch_alloc i_alloc (
		.clk       (clk),
		.reset     (reset),
		.req       (req),
		.is_tail   (is_tail),
		.credit_in (credit_in),
		.grant     (grant)
	);

	crossbar i_xbar (
		.clk          (clk),
		.reset        (reset),
		.granted_dest (grant),
		.flit_head    (head_flit),
		.flit_out     (flit_out),
		.flit_out_we  (flit_out_we)
	);

endmodule

`default_nettype wire

//--- bench/router_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "noc_macros.svh"

module router_tb;

	localparam int MY_X    = 2;
	localparam int MY_Y    = 2;
	localparam int TIMEOUT = 500; // cycles per wait

	logic                reset;
	logic                clk;
	noc_pkg::flit_t      flit_in [`NOC_P];
	noc_pkg::port_vec_t  flit_in_we;
	noc_pkg::port_vec_t  credit_out;
	noc_pkg::flit_t      flit_out [`NOC_P];
	noc_pkg::port_vec_t  flit_out_we;
	noc_pkg::port_vec_t  credit_in = '0;

	noc_pkg::flit_t      rx_q [`NOC_P][$];  // collected per output
	noc_pkg::flit_t      exp_q [`NOC_P][$]; // expected per output
	noc_pkg::flit_t      src_q [`NOC_P][$]; // sent per input
	int                  sent [`NOC_P] = '{default: 0};
	int                  ret [`NOC_P] = '{default: 0};  // credit_out pulses seen
	int                  owed [`NOC_P] = '{default: 0}; // credits not yet returned downstream
	noc_pkg::port_vec_t  hold = '0;
	int                  seed = 61136;
	int                  checks = 0;
	int                  errors = 0;
	int                  tests = 0;
	int                  failed = 0;
	int                  test_err0 = 0;
	string               cur_test = "none";

	initial clk = 1'b0;
	always #5 clk = ~clk;

	router_switch #(
		.ROUTER_X (MY_X),
		.ROUTER_Y (MY_Y)
	) i_dut (
		.clk         (clk),
		.reset       (reset),
		.flit_in     (flit_in),
		.flit_in_we  (flit_in_we),
		.credit_out  (credit_out),
		.flit_out    (flit_out),
		.flit_out_we (flit_out_we),
		.credit_in   (credit_in)
	);

	// collector and downstream credit return
	always @(posedge clk) begin
		#1;
		for (int p = 0; p < `NOC_P; p++) begin
			if (flit_out_we[p]) begin
				rx_q[p].push_back(flit_out[p]);
				owed[p]++;
			end
			if (credit_out[p]) begin
				ret[p]++;
			end
			if (!hold[p] && owed[p] > 0) begin
				credit_in[p] = 1'b1;
				owed[p]--;
			end else begin
				credit_in[p] = 1'b0;
			end
		end
	end

	task automatic check_val(input logic [63:0] exp_v, input logic [63:0] act_v);
		checks++;
		if (exp_v !== act_v) begin
			errors++;
			$display("ERR %s expected %h actual %h", cur_test, exp_v, act_v);
		end
	endtask

	// x first, then y; north is growing y
	function automatic int route_of(input int dx, input int dy);
		if (dx > MY_X) begin
			return `NOC_PORT_EAST;
		end else if (dx < MY_X) begin
			return `NOC_PORT_WEST;
		end else if (dy > MY_Y) begin
			return `NOC_PORT_NORTH;
		end else if (dy < MY_Y) begin
			return `NOC_PORT_SOUTH;
		end
		return `NOC_PORT_LOCAL;
	endfunction

	function automatic noc_pkg::flit_t make_flit(input logic hd, input logic tl,
			input int dx, input int dy);
		noc_pkg::flit_t f;
		logic [31:0]    r;
		r = $random(seed);
		f.head = hd;
		f.tail = tl;
		f.data.raw = r;
		if (hd) begin
			f.data.hdr.dest_x = dx[3:0];
			f.data.hdr.dest_y = dy[3:0];
		end
		return f;
	endfunction

	task automatic send_flit(input int p, input noc_pkg::flit_t f);
		int t;
		t = 0;
		@(negedge clk);
		while (sent[p] - ret[p] >= `NOC_BUF_DEPTH && t < TIMEOUT) begin
			@(negedge clk);
			t++;
		end
		if (t >= TIMEOUT) begin
			errors++;
			$display("%s: input %0d never got a credit back", cur_test, p);
		end else begin
			@(posedge clk);
			#1;
			flit_in[p] = f;
			flit_in_we[p] = 1'b1;
			sent[p]++;
			@(posedge clk);
			#1;
			flit_in_we[p] = 1'b0;
		end
	endtask

	task automatic send_packet(input int src, input int dx, input int dy, input int n);
		noc_pkg::flit_t f;
		int             dst;
		dst = route_of(dx, dy);
		for (int k = 0; k < n; k++) begin
			f = make_flit(k == 0, k == n - 1, dx, dy);
			exp_q[dst].push_back(f);
			src_q[src].push_back(f);
			send_flit(src, f);
		end
	endtask

	task automatic wait_rx(input int p, input int n);
		int t;
		t = 0;
		@(negedge clk);
		while (rx_q[p].size() < n && t < TIMEOUT) begin
			@(negedge clk);
			t++;
		end
		if (rx_q[p].size() < n) begin
			errors++;
			$display("%s: output %0d got only %0d of %0d flits before the timeout",
				cur_test, p, rx_q[p].size(), n);
		end
	endtask

	task automatic wait_expected();
		for (int p = 0; p < `NOC_P; p++) begin
			wait_rx(p, exp_q[p].size());
		end
	endtask

	task automatic compare_all();
		for (int p = 0; p < `NOC_P; p++) begin
			check_val(64'(exp_q[p].size()), 64'(rx_q[p].size()));
			for (int k = 0; k < exp_q[p].size() && k < rx_q[p].size(); k++) begin
				check_val(64'(exp_q[p][k]), 64'(rx_q[p][k]));
			end
		end
	endtask

	task automatic start_test(input string name);
		@(negedge clk);
		cur_test = name;
		test_err0 = errors;
		for (int p = 0; p < `NOC_P; p++) begin
			rx_q[p].delete();
			exp_q[p].delete();
			src_q[p].delete();
		end
	endtask

	task automatic end_test();
		tests++;
		if (errors == test_err0) begin
			$display("%s: ok", cur_test);
		end else begin
			failed++;
			$display("%s: %0d errors", cur_test, errors - test_err0);
		end
	endtask

	task automatic reset_values();
		start_test("reset");
		check_val(64'd0, 64'(flit_out_we));
		check_val(64'd0, 64'(credit_out));
		end_test();
	endtask

	task automatic routing_single();
		start_test("routing");
		send_packet(`NOC_PORT_LOCAL, 3, 2, 1);
		send_packet(`NOC_PORT_LOCAL, 1, 2, 1);
		send_packet(`NOC_PORT_LOCAL, 2, 3, 1);
		send_packet(`NOC_PORT_LOCAL, 2, 1, 1);
		send_packet(`NOC_PORT_EAST, 2, 2, 1); // local output, from east
		wait_expected();
		compare_all();
		end_test();
	endtask

	task automatic multi_flit_packet();
		int r0;
		start_test("multi_flit");
		r0 = ret[`NOC_PORT_WEST];
		send_packet(`NOC_PORT_WEST, 4, 2, 4);
		wait_expected();
		compare_all();
		check_val(64'd4, 64'(ret[`NOC_PORT_WEST] - r0));
		end_test();
	endtask

	task automatic output_contention();
		int first;
		int second;
		start_test("contention");
		fork
			send_packet(`NOC_PORT_NORTH, 2, 2, 3);
			send_packet(`NOC_PORT_SOUTH, 2, 2, 3);
		join
		wait_expected();
		check_val(64'd6, 64'(rx_q[`NOC_PORT_LOCAL].size()));
		if (rx_q[`NOC_PORT_LOCAL].size() == 6) begin
			first = (rx_q[`NOC_PORT_LOCAL][0] == src_q[`NOC_PORT_NORTH][0]) ?
				`NOC_PORT_NORTH : `NOC_PORT_SOUTH;
			second = (first == `NOC_PORT_NORTH) ? `NOC_PORT_SOUTH : `NOC_PORT_NORTH;
			for (int k = 0; k < 3; k++) begin
				check_val(64'(src_q[first][k]), 64'(rx_q[`NOC_PORT_LOCAL][k]));
				check_val(64'(src_q[second][k]), 64'(rx_q[`NOC_PORT_LOCAL][k + 3]));
			end
		end
		end_test();
	endtask

	task automatic east_backpressure();
		start_test("backpressure");
		hold[`NOC_PORT_EAST] = 1'b1;
		send_packet(`NOC_PORT_LOCAL, 3, 2, 6);
		wait_rx(`NOC_PORT_EAST, `NOC_BUF_DEPTH);
		repeat (20) @(negedge clk); // nothing more may leave
		check_val(64'(`NOC_BUF_DEPTH), 64'(rx_q[`NOC_PORT_EAST].size()));
		hold[`NOC_PORT_EAST] = 1'b0;
		wait_expected();
		compare_all();
		end_test();
	endtask

	task automatic concurrent_traffic();
		int len [`NOC_P];
		start_test("concurrent");
		for (int p = 0; p < `NOC_P; p++) begin
			len[p] = 1 + ($random(seed) & 3);
		end
		fork
			send_packet(`NOC_PORT_LOCAL, 3, 2, len[0]);
			send_packet(`NOC_PORT_EAST, 1, 2, len[1]);
			send_packet(`NOC_PORT_NORTH, 2, 1, len[2]);
			send_packet(`NOC_PORT_WEST, 2, 2, len[3]);
			send_packet(`NOC_PORT_SOUTH, 2, 3, len[4]);
		join
		wait_expected();
		compare_all();
		end_test();
	endtask

	initial begin
		reset = 1'b1;
		flit_in_we = '0;
		for (int p = 0; p < `NOC_P; p++) begin
			flit_in[p] = '0;
		end
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;
		reset_values();
		routing_single();
		multi_flit_packet();
		output_contention();
		east_backpressure();
		concurrent_traffic();
		$display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- router_switch.f
+incdir+hdl
hdl/noc_pkg.sv
hdl/input_port.sv
hdl/switch_alloc.sv
hdl/crossbar.sv
hdl/router_switch.sv
bench/router_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the router testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -j 0 -f router_switch.f --top-module router_tb -o router_tb
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/router_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
	echo "simulation reported failure"
	exit 1
fi

echo "simulation finished, see $LOG"
exit 0
